// File: logic/clock_pkg.sv
// clock circuit definitions shared by the divider, the step selector and the top level
package clock_pkg;

    // main_clock cycles per half period of the slow square wave
    // 100 MHz board clock / 50e6 gives a 1 Hz wave
    localparam int default_div_value = 50_000_000;

    // front panel switches and button that steer the step clock
    typedef struct packed {
        logic select_astable; // 1 = free running astable, 0 = manual button
        logic manual_pulse;   // raw button level, not synchronized yet
        logic hlt;            // 1 = halt, no steps from either source
    } clock_ctrl_t;

endpackage : clock_pkg

// File: logic/memory_pkg.sv
// memory side definitions: data byte, address and the command bundle
package memory_pkg;

    // size of the memory
    localparam int default_addr_width = 4;                       // 4 address switches
    localparam int mem_depth          = 1 << default_addr_width; // 16 bytes

    typedef logic [7:0] byte_t;                     // one data byte
    typedef logic [default_addr_width-1:0] addr_t;  // plain binary index

    // one memory command, held by the switches until the step arrives
    // layout msb first: load, read, addr[3:0], data[7:0] = 14 bits
    typedef struct packed {
        logic  load_enable; // write data into mem[addr] and data_reg
        logic  read_enable; // copy mem[addr] onto the bus register
        addr_t addr;        // byte to act on
        byte_t data;        // write data
    } mem_cmd_t;

endpackage : memory_pkg

// File: logic/astable_pulse.sv
`timescale 1ns/100ps

// slow square wave from main_clock plus a one cycle tick per rising edge
// one_hz toggles every DIV_VALUE cycles, so rising edges are 2*DIV_VALUE apart
module astable_pulse import clock_pkg::*; #(
    parameter int DIV_VALUE = default_div_value // cycles per half period
) (
    input  logic main_clock,
    input  logic rst_n,
    output logic one_hz,       // slow square wave, also drives the board led
    output logic astable_tick  // one cycle pulse, cycle after one_hz rises
);

    // counter just wide enough for 0 .. DIV_VALUE-1
    localparam int CNT_W = (DIV_VALUE > 1) ? $clog2(DIV_VALUE) : 1;

    logic [CNT_W-1:0] div_count;
    logic             wrap;      // last cycle of a half period
    logic             one_hz_q;  // one_hz one cycle late, for the edge detect

    assign wrap = (div_count == CNT_W'(DIV_VALUE - 1));

    always_ff @(posedge main_clock or negedge rst_n) begin
        if (!rst_n) begin
            div_count <= '0;
            one_hz    <= 1'b0;
        end else if (wrap) begin
            div_count <= '0;
            one_hz    <= ~one_hz; // half period done
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    // register the rising edge of one_hz into a single tick
    always_ff @(posedge main_clock or negedge rst_n) begin
        if (!rst_n) begin
            one_hz_q     <= 1'b0;
            astable_tick <= 1'b0;
        end else begin
            one_hz_q     <= one_hz;
            astable_tick <= one_hz & ~one_hz_q; // high only on the 0->1 step
        end
    end

    // the tick must stay a single cycle pulse, the memory steps once per tick
    a_tick_one_cycle: assert property (
        @(posedge main_clock) disable iff (!rst_n)
        astable_tick |=> !astable_tick
    ) else $error("astable_tick high for more than one cycle");

endmodule : astable_pulse

// File: logic/step_clock_ctrl.sv
`timescale 1ns/100ps

// step clock selector
// the manual button goes through a 2 flop synchronizer and an edge detect for one pulse per press
// the astable source is the tick from the divider
// the chosen source is gated by hlt and registered into cpu_step
module step_clock_ctrl import clock_pkg::*; (
    input  logic        main_clock,
    input  logic        rst_n,
    input  clock_ctrl_t clock_ctrl,   // select, button, halt
    input  logic        astable_tick, // one cycle pulse from astable_pulse
    output logic        cpu_step      // one cycle step enable for the memory
);

    logic btn_meta;    // first synchronizer stage that may go metastable
    logic btn_sync;    // second stage that is safe to use
    logic btn_q;       // btn_sync delayed for the edge detect
    logic manual_edge; // rising edge of the synchronized button
    logic step_src;    // selected step source before halt

    // button comes straight from the board pin without debounce
    always_ff @(posedge main_clock or negedge rst_n) begin
        if (!rst_n) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
            btn_q    <= 1'b0;
        end else begin
            btn_meta <= clock_ctrl.manual_pulse;
            btn_sync <= btn_meta;
            btn_q    <= btn_sync;
        end
    end

    // press sampled at edge N shows here after edge N+1
    assign manual_edge = btn_sync & ~btn_q;

    // the other source is simply ignored
    always_comb begin
        if (clock_ctrl.select_astable) begin
            step_src = astable_tick;
        end else begin
            step_src = manual_edge;
        end
    end

    // registered step puts cpu_step high in the cycle after edge N+2
    // in astable mode it trails astable_tick by one cycle
    always_ff @(posedge main_clock or negedge rst_n) begin
        if (!rst_n) begin
            cpu_step <= 1'b0;
        end else begin
            cpu_step <= step_src & ~clock_ctrl.hlt; // halt blocks both sources
        end
    end

    // halt seen at one edge means no step in the following cycle
    a_halt_blocks_step: assert property (
        @(posedge main_clock) disable iff (!rst_n)
        clock_ctrl.hlt |=> !cpu_step
    ) else $error("cpu_step high after hlt was sampled high");

endmodule : step_clock_ctrl

// File: logic/byte_memory.sv
`timescale 1ns/100ps

// sixteen byte memory with a data register and a bus register
// everything happens on main_clock edges where cpu_step is high
//   load_enable writes data to mem[addr] and data_reg
//   read_enable copies mem[addr] to bus_out and sees the old byte when load is set too
// cpu_step low means nothing moves
module byte_memory import memory_pkg::*; (
    input  logic     main_clock,
    input  logic     rst_n,
    input  logic     cpu_step, // one cycle step from the clock circuit
    input  mem_cmd_t mem_cmd,  // held stable by the switches while a step is pending
    output byte_t    data_reg, // last byte written
    output byte_t    bus_out   // last byte read
);

    byte_t mem [mem_depth]; // the sixteen bytes indexed by binary address

    logic do_load; // write on this edge
    logic do_read; // read on this edge

    assign do_load = cpu_step & mem_cmd.load_enable;
    assign do_read = cpu_step & mem_cmd.read_enable;

    // storage array cleared to zero on reset
    always_ff @(posedge main_clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (do_load) begin
            mem[mem_cmd.addr] <= mem_cmd.data; // only the addressed byte changes
        end
    end

    // data register follows every write
    always_ff @(posedge main_clock or negedge rst_n) begin
        if (!rst_n) begin
            data_reg <= '0;
        end else if (do_load) begin
            data_reg <= mem_cmd.data;
        end
    end

    // bus register
    // the non-blocking read of mem misses a load on the same edge
    always_ff @(posedge main_clock or negedge rst_n) begin
        if (!rst_n) begin
            bus_out <= '0;
        end else if (do_read) begin
            bus_out <= mem[mem_cmd.addr]; // byte as it was before this edge
        end
    end

    // without a step both output registers hold their value
    a_hold_without_step: assert property (
        @(posedge main_clock) disable iff (!rst_n)
        !cpu_step |=> ($stable(bus_out) && $stable(data_reg))
    ) else $error("memory outputs changed without cpu_step");

endmodule : byte_memory

// File: logic/cpu_memory_top.sv
`timescale 1ns/100ps

// memory side of the 8 bit computer with its step clock
// astable_pulse -> step_clock_ctrl -> byte_memory, all on main_clock
module cpu_memory_top import clock_pkg::*; import memory_pkg::*; #(
    parameter int DIV_VALUE = default_div_value // half period of one_hz in cycles
) (
    input  logic        main_clock,
    input  logic        rst_n,
    input  clock_ctrl_t clock_ctrl, // select switch, step button, halt switch
    input  mem_cmd_t    mem_cmd,    // load, read, address and data switches
    output logic        one_hz,     // slow wave for the board led
    output logic        cpu_step,   // step pulse, also to the led / rest of the cpu
    output byte_t       data_reg,
    output byte_t       bus_out
);

    logic astable_tick; // divider tick into the selector

    // slow clock source
    astable_pulse #(
        .DIV_VALUE    (DIV_VALUE)
    ) astable_pulse_i (
        .main_clock   (main_clock),
        .rst_n        (rst_n),
        .one_hz       (one_hz),
        .astable_tick (astable_tick)
    );

    // picks manual or astable, applies halt
    step_clock_ctrl step_clock_ctrl_i (
        .main_clock   (main_clock),
        .rst_n        (rst_n),
        .clock_ctrl   (clock_ctrl),
        .astable_tick (astable_tick),
        .cpu_step     (cpu_step)
    );

    // sixteen bytes, stepped by cpu_step
    byte_memory byte_memory_i (
        .main_clock (main_clock),
        .rst_n      (rst_n),
        .cpu_step   (cpu_step),
        .mem_cmd    (mem_cmd),
        .data_reg   (data_reg),
        .bus_out    (bus_out)
    );

endmodule : cpu_memory_top

// File: tests/tb_cpu_memory.sv
`timescale 1ns/100ps

// testbench for cpu_memory_top
// manual steps come from a table of commands with expected register values
// astable mode is checked over a fixed window at the end
module tb_cpu_memory import clock_pkg::*; import memory_pkg::*; ();

    localparam int TB_DIV = 4; // half period of one_hz in cycles

    localparam logic [1:0] MODE_MANUAL = 2'd0; // press with hlt low and expect one step
    localparam logic [1:0] MODE_HALT   = 2'd1; // press with hlt high and expect no step

    // one row of the stimulus table
    typedef struct packed {
        logic [1:0] mode;
        logic       load;
        logic       read;
        addr_t      addr;
        byte_t      data;
        byte_t      exp_data_reg; // data_reg after the step
        byte_t      exp_bus_out;  // bus_out after the step
    } step_entry_t;

    logic        main_clock;
    logic        rst_n;
    clock_ctrl_t clock_ctrl;
    mem_cmd_t    mem_cmd;
    logic        one_hz;
    logic        cpu_step;
    byte_t       data_reg;
    byte_t       bus_out;

    step_entry_t step_table [$];

    // reference model of the memory side
    byte_t model_mem [mem_depth];
    byte_t model_data_reg;
    byte_t model_bus;

    logic [31:0] lfsr_state; // random source for data bytes

    cpu_memory_top #(
        .DIV_VALUE  (TB_DIV)
    ) cpu_memory_top_i (
        .main_clock (main_clock),
        .rst_n      (rst_n),
        .clock_ctrl (clock_ctrl),
        .mem_cmd    (mem_cmd),
        .one_hz     (one_hz),
        .cpu_step   (cpu_step),
        .data_reg   (data_reg),
        .bus_out    (bus_out)
    );

    initial main_clock = 1'b0;
    always #20 main_clock = ~main_clock; // 40 ns period

    // one right shift step of a 32 bit galois lfsr
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003; // taps 32 22 2 1
        end
        return n;
    endfunction

    // eight lfsr steps with one bit taken per step
    function automatic byte_t random_byte();
        byte_t b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b          = {b[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return b;
    endfunction

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // failures that are not a value mismatch
    task automatic report_failure(input string what);
        $display("%s (time %0t)", what, $time);
        stop_run();
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // run the model on one command and append the row with its expected values
    task automatic add_entry(input logic [1:0] mode, input logic load, input logic read,
                             input addr_t addr, input byte_t data);
        step_entry_t e;
        if (mode == MODE_MANUAL) begin
            if (read) begin
                model_bus = model_mem[addr]; // taken before the write below
            end
            if (load) begin
                model_mem[addr] = data;
                model_data_reg  = data;
            end
        end
        e.mode         = mode;
        e.load         = load;
        e.read         = read;
        e.addr         = addr;
        e.data         = data;
        e.exp_data_reg = model_data_reg;
        e.exp_bus_out  = model_bus;
        step_table.push_back(e);
    endtask

    task automatic build_table();
        // reads of a freshly reset memory
        for (int a = 0; a < mem_depth; a++) begin
            add_entry(MODE_MANUAL, 1'b0, 1'b1, addr_t'(a), 8'h00);
        end
        for (int a = 0; a < mem_depth; a++) begin
            add_entry(MODE_MANUAL, 1'b1, 1'b0, addr_t'(a), random_byte()); // fill
        end
        for (int a = 0; a < mem_depth; a++) begin
            add_entry(MODE_MANUAL, 1'b0, 1'b1, addr_t'(a), 8'h00);         // read back
        end
        add_entry(MODE_MANUAL, 1'b0, 1'b1, 4'd3, random_byte()); // read only with data ignored
        add_entry(MODE_MANUAL, 1'b0, 1'b0, 4'd5, random_byte()); // idle step
        add_entry(MODE_MANUAL, 1'b1, 1'b1, 4'd7, random_byte()); // load and read together
        add_entry(MODE_MANUAL, 1'b0, 1'b1, 4'd7, 8'h00);         // new byte now visible
        add_entry(MODE_HALT,   1'b1, 1'b1, 4'd2, random_byte()); // blocked by hlt
        add_entry(MODE_MANUAL, 1'b0, 1'b1, 4'd2, 8'h00);         // still the old byte
        add_entry(MODE_MANUAL, 1'b1, 1'b0, 4'd2, random_byte()); // halt released
        add_entry(MODE_MANUAL, 1'b0, 1'b1, 4'd2, 8'h00);
    endtask

    // set the command, then hold the button high for two cycles
    task automatic press_button(input step_entry_t e);
        mem_cmd_t    cmd;
        clock_ctrl_t ctrl;
        cmd.load_enable     = e.load;
        cmd.read_enable     = e.read;
        cmd.addr            = e.addr;
        cmd.data            = e.data;
        ctrl.select_astable = 1'b0;
        ctrl.manual_pulse   = 1'b0;
        ctrl.hlt            = (e.mode == MODE_HALT);
        @(posedge main_clock);
        mem_cmd    <= cmd;
        clock_ctrl <= ctrl;
        @(posedge main_clock);
        clock_ctrl.manual_pulse <= 1'b1;
        repeat (2) @(posedge main_clock);
        clock_ctrl.manual_pulse <= 1'b0;
    endtask

    task automatic check_outputs(input step_entry_t e);
        check("data_reg", 32'(data_reg), 32'(e.exp_data_reg));
        check("bus_out", 32'(bus_out), 32'(e.exp_bus_out));
    endtask

    task automatic manual_step(input step_entry_t e);
        int waited;
        press_button(e);
        for (waited = 0; waited < 20; waited++) begin
            @(negedge main_clock); // sample away from the driving edge
            if (cpu_step === 1'b1) begin
                break;
            end
        end
        if (waited == 20) begin
            report_failure("timeout: no cpu_step within 20 cycles of a button press");
        end
        @(negedge main_clock); // the memory acted on the edge inside the pulse
        check("cpu_step", 32'(cpu_step), 32'd0); // one cycle wide
        check_outputs(e);
    endtask

    task automatic halted_press(input step_entry_t e);
        press_button(e);
        for (int n = 0; n < 20; n++) begin
            @(negedge main_clock);
            if (cpu_step !== 1'b0) begin
                report_failure("cpu_step pulsed while hlt was high");
            end
        end
        check_outputs(e);
    endtask

    // free running steps with a read held and the button pressed halfway through
    task automatic astable_window(input addr_t addr);
        mem_cmd_t cmd;
        int       pulses;
        int       toggles;
        int       last_pulse;
        int       last_toggle;
        logic     prev_step;
        logic     prev_hz;
        cmd             = '0;
        cmd.read_enable = 1'b1;
        cmd.addr        = addr;
        pulses          = 0;
        toggles         = 0;
        last_pulse      = -1;
        last_toggle     = -1;
        @(posedge main_clock);
        mem_cmd    <= cmd;
        clock_ctrl <= '{select_astable: 1'b1, manual_pulse: 1'b0, hlt: 1'b0};
        repeat (2) @(posedge main_clock); // selector output now follows the tick
        @(negedge main_clock);
        prev_step = cpu_step;
        prev_hz   = one_hz;
        for (int cyc = 0; cyc < 64; cyc++) begin
            @(posedge main_clock);
            clock_ctrl.manual_pulse <= (cyc >= 20 && cyc < 22); // must be ignored
            @(negedge main_clock);
            if (cpu_step === 1'b1) begin
                check("cpu_step previous cycle", 32'(prev_step), 32'd0);
                if (last_pulse >= 0) begin
                    check("astable step spacing", cyc - last_pulse, 2 * TB_DIV);
                end
                last_pulse = cyc;
                pulses++;
            end
            if (one_hz !== prev_hz) begin
                if (last_toggle >= 0) begin
                    check("one_hz half period", cyc - last_toggle, TB_DIV);
                end
                last_toggle = cyc;
                toggles++;
            end
            prev_step = cpu_step;
            prev_hz   = one_hz;
        end
        check("astable step count", pulses, 64 / (2 * TB_DIV));
        check("one_hz toggle count", toggles, 64 / TB_DIV);
        model_bus = model_mem[addr]; // the held read repeats on every pulse
        check("bus_out", 32'(bus_out), 32'(model_bus));
        check("data_reg", 32'(data_reg), 32'(model_data_reg));
    endtask

    initial begin
        rst_n      <= 1'b0;
        clock_ctrl <= '0;
        mem_cmd    <= '0;
        lfsr_state = 32'he804;
        model_data_reg = '0;
        model_bus      = '0;
        for (int a = 0; a < mem_depth; a++) begin
            model_mem[a] = '0;
        end
        build_table();

        repeat (8) @(posedge main_clock);
        rst_n <= 1'b1;
        @(negedge main_clock);
        check("data_reg", 32'(data_reg), 32'd0);
        check("bus_out", 32'(bus_out), 32'd0);
        check("cpu_step", 32'(cpu_step), 32'd0);
        check("one_hz", 32'(one_hz), 32'd0);

        foreach (step_table[i]) begin
            if (step_table[i].mode == MODE_HALT) begin
                halted_press(step_table[i]);
            end else begin
                manual_step(step_table[i]);
            end
        end

        astable_window(4'd9); // address filled earlier with a random byte

        $display("All tests passed");
        $finish;
    end

endmodule : tb_cpu_memory

// File: files.f
logic/clock_pkg.sv
logic/memory_pkg.sv
logic/astable_pulse.sv
logic/step_clock_ctrl.sv
logic/byte_memory.sv
logic/cpu_memory_top.sv
tests/tb_cpu_memory.sv

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_cpu_memory -f files.f -o tb_cpu_memory_sim \
    && ./obj_dir/tb_cpu_memory_sim | tee sim.log \
    || echo "build or simulation stopped with an error"

grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
